//--- Makefile
# Verilator build and run of the posit accumulator testbench

VERILATOR ?= verilator
TOP       ?= posit_accum_tb
LOG       ?= sim.log
SEED      ?= 1390464589
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Gseed_init=$(SEED) --Mdir $(OBJ_DIR) -f project.f
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- project.f
+incdir+verilog
verilog/accum_pkg.sv
verilog/accum_stage_if.sv
verilog/accum_ctrl.sv
verilog/operand_align.sv
verilog/sum_normalize.sv
verilog/posit_accum_top.sv
tests/posit_accum_assertions.sv
tests/posit_accum_tb.sv

//--- tests/posit_accum_assertions.sv
/*
 * Handshake and latency checks bound to the posit accumulator top
 */
`timescale 1ns/1ps

module posit_accum_assertions (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic clear,
    input logic in_ready,
    input logic busy,
    input logic result_valid
);

    logic accept;
    int   fail_count = 0;

    // A clear launches no addition
    assign accept = in_valid & in_ready & ~clear;

    // Input stays blocked from the acceptance edge until the sum update edge
    ready_low_in_flight: assert property (@(posedge clk) disable iff (rst)
        ($past(accept, 1) || $past(accept, 2) || $past(accept, 3) || $past(accept, 4))
        |-> (busy && !in_ready))
    else
    begin
        $error("in_ready high while an addition is in flight");
        fail_count++;
    end

    ready_after_update: assert property (@(posedge clk) disable iff (rst)
        $past(accept, 5) |-> (!busy && in_ready))
    else
    begin
        $error("in_ready still low after the sum update");
        fail_count++;
    end

    // The pulse set at the fourth edge after acceptance is sampled one edge later
    result_after_accept: assert property (@(posedge clk) disable iff (rst)
        $past(accept, 5) |-> result_valid)
    else
    begin
        $error("result_valid missing four cycles after acceptance");
        fail_count++;
    end

    result_needs_accept: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> $past(accept, 5))
    else
    begin
        $error("result_valid without an acceptance four cycles earlier");
        fail_count++;
    end

    result_single_pulse: assert property (@(posedge clk) disable iff (rst)
        result_valid |=> !result_valid)
    else
    begin
        $error("result_valid longer than one cycle");
        fail_count++;
    end

endmodule

bind posit_accum_top posit_accum_assertions assert0 (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .clear        (clear),
    .in_ready     (in_ready),
    .busy         (busy),
    .result_valid (result_valid)
);

//--- tests/posit_accum_tb.sv
/*
 * Posit accumulator testbench applying a table of additions and clears with
 * random idle gaps and checking sums, sticky flags, latency and back-pressure
 */
`timescale 1ns/1ps
`include "accum_macros.svh"

module posit_accum_tb;

    parameter logic [31:0] seed_init = 32'h52e0_ce4d;
    localparam int max_gap = 7;

    typedef struct packed {
        logic                   clear;
        accum_pkg::value_in_t   value;
        accum_pkg::value_acc_t  expect_sum;
        logic                   expect_trunc;
    } entry_t;

    typedef struct packed {
        accum_pkg::value_acc_t  expect_sum;
        logic                   expect_trunc;
        logic [31:0]            accept_cycle;
    } pending_t;

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    logic                       clear;
    logic [`ACC_IN_WIDTH-1:0]   in_value;
    logic                       in_ready;
    logic                       result_valid;
    logic                       busy;
    logic                       truncated;
    logic [`ACC_OUT_WIDTH-1:0]  result;

    entry_t                 stim_table[$];
    pending_t               pending[$];
    pending_t               launch;
    pending_t               head;
    accum_pkg::value_acc_t  zero_sum;
    accum_pkg::value_acc_t  inf_sum;
    integer                 seed;
    int                     gap;
    int                     cycle_count = 0;
    int                     timeout_limit = 1000;
    int                     error_count = 0;
    int                     result_count = 0;
    int                     add_count = 0;

    posit_accum_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .clear        (clear),
        .in_value     (in_value),
        .in_ready     (in_ready),
        .result_valid (result_valid),
        .busy         (busy),
        .truncated    (truncated),
        .result       (result)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    function automatic accum_pkg::value_in_t input_fields(input logic sign,
        input logic [`ACC_SCALE_BITS-1:0] scale, input logic [`ACC_IN_FBITS-1:0] frac,
        input logic inf);
        return {sign, scale, frac, inf, 1'b0};
    endfunction

    function automatic accum_pkg::value_acc_t sum_fields(input logic sign,
        input logic [`ACC_SCALE_BITS-1:0] scale, input logic [`ACC_FBITS-1:0] frac,
        input logic inf, input logic zero);
        return {sign, scale, frac, inf, zero};
    endfunction

    task automatic push_addition(input accum_pkg::value_in_t v,
        input accum_pkg::value_acc_t s, input logic trunc);
        stim_table.push_back({1'b0, v, s, trunc});
        add_count++;
    endtask

    // A value offered with the clear must not reach the sum
    task automatic queue_clear();
        stim_table.push_back({1'b1, input_fields(1'b0, 8'h05, 27'h123, 1'b0), zero_sum, 1'b0});
    endtask

    task automatic compare_field(input string name, input logic [63:0] expected,
        input logic [63:0] actual);
        assert (expected === actual)
        else
        begin
            $display("ERROR %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    // Only the flags are defined once inf is set
    task automatic check_sum(input accum_pkg::value_acc_t s, input logic trunc);
        accum_pkg::value_acc_t got;
        got = result;
        if (s.inf)
        begin
            compare_field("result.inf", 64'd1, 64'(got.inf));
            compare_field("result.zero", 64'd0, 64'(got.zero));
        end
        else
            compare_field("result", 64'(s), 64'(got));
        compare_field("truncated", 64'(trunc), 64'(truncated));
    endtask

    task automatic build_table();
        accum_pkg::value_in_t one_p5;
        one_p5 = input_fields(1'b0, 8'h00, 27'h400_0000, 1'b0);
        queue_clear();
        push_addition(one_p5, sum_fields(1'b0, 8'h00, 40'h80_0000_0000, 1'b0, 1'b0), 1'b0);
        push_addition(one_p5, sum_fields(1'b0, 8'h01, 40'h80_0000_0000, 1'b0, 1'b0), 1'b0);
        queue_clear();
        push_addition(input_fields(1'b0, 8'h03, 27'h0, 1'b0),
                      sum_fields(1'b0, 8'h03, 40'h0, 1'b0, 1'b0), 1'b0);
        push_addition(input_fields(1'b0, 8'hfe, 27'h0, 1'b0),
                      sum_fields(1'b0, 8'h03, 40'h08_0000_0000, 1'b0, 1'b0), 1'b0);
        queue_clear();
        push_addition(input_fields(1'b0, 8'h02, 27'h0, 1'b0),
                      sum_fields(1'b0, 8'h02, 40'h0, 1'b0, 1'b0), 1'b0);
        push_addition(input_fields(1'b1, 8'h02, 27'h0, 1'b0), zero_sum, 1'b0);
        push_addition(input_fields(1'b1, 8'h01, 27'h400_0000, 1'b0),
                      sum_fields(1'b1, 8'h01, 40'h80_0000_0000, 1'b0, 1'b0), 1'b0);
        push_addition(input_fields(1'b0, 8'h00, 27'h0, 1'b0),
                      sum_fields(1'b1, 8'h01, 40'h0, 1'b0, 1'b0), 1'b0);
        // -2 plus 1.5 cancels the two upper bits and needs a left shift
        push_addition(input_fields(1'b0, 8'h00, 27'h400_0000, 1'b0),
                      sum_fields(1'b1, 8'hff, 40'h0, 1'b0, 1'b0), 1'b0);
        queue_clear();
        // 2^-60 lies far below the adder of a 2^20 sum
        push_addition(input_fields(1'b0, 8'h14, 27'h0, 1'b0),
                      sum_fields(1'b0, 8'h14, 40'h0, 1'b0, 1'b0), 1'b0);
        push_addition(input_fields(1'b0, 8'hc4, 27'h1, 1'b0),
                      sum_fields(1'b0, 8'h14, 40'h0, 1'b0, 1'b0), 1'b1);
        queue_clear();
        push_addition(input_fields(1'b0, 8'h00, 27'h0, 1'b1), inf_sum, 1'b0);
        push_addition(input_fields(1'b0, 8'h03, 27'h400_0000, 1'b0), inf_sum, 1'b0);
        push_addition(input_fields(1'b1, 8'h00, 27'h0, 1'b0), inf_sum, 1'b0);
        queue_clear();
        push_addition(input_fields(1'b0, 8'h00, 27'h0, 1'b0),
                      sum_fields(1'b0, 8'h00, 40'h0, 1'b0, 1'b0), 1'b0);
    endtask

    // Each result is matched against the oldest accepted addition
    always @(negedge clk)
    begin
        if (!rst && result_valid)
        begin
            result_count++;
            assert (pending.size() > 0)
            else
            begin
                $display("result_valid pulsed with no addition in flight");
                error_count++;
            end
            if (pending.size() > 0)
            begin
                head = pending.pop_front();
                compare_field("latency", 64'd4, 64'(cycle_count - int'(head.accept_cycle)));
                check_sum(head.expect_sum, head.expect_trunc);
            end
        end
    end

    initial
    begin
        wait (cycle_count >= timeout_limit);
        $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        clear    = 1'b0;
        in_value = '0;
        seed     = seed_init;
        zero_sum = sum_fields(1'b0, 8'h00, 40'h0, 1'b0, 1'b1);
        inf_sum  = sum_fields(1'b0, 8'h00, 40'h0, 1'b1, 1'b0);
        build_table();
        timeout_limit = stim_table.size() * (4 + max_gap) + 40;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_field("in_ready", 64'd1, 64'(in_ready));
        compare_field("busy", 64'd0, 64'(busy));
        compare_field("result_valid", 64'd0, 64'(result_valid));
        check_sum(zero_sum, 1'b0);

        foreach (stim_table[i])
        begin
            gap = $unsigned($random(seed)) % (max_gap + 1);
            repeat (gap) @(negedge clk);
            // in_valid stays up with the clear so that clear priority is exercised
            in_valid = 1'b1;
            clear    = stim_table[i].clear;
            in_value = stim_table[i].value;
            while (!in_ready)
                @(negedge clk);
            if (!stim_table[i].clear)
            begin
                launch.expect_sum   = stim_table[i].expect_sum;
                launch.expect_trunc = stim_table[i].expect_trunc;
                launch.accept_cycle = 32'(cycle_count + 1);
                pending.push_back(launch);
            end
            @(negedge clk);
            in_valid = 1'b0;
            clear    = 1'b0;
            if (stim_table[i].clear)
                check_sum(zero_sum, 1'b0);
        end

        while (pending.size() != 0)
            @(negedge clk);
        repeat (6) @(negedge clk);
        compare_field("result_valid count", 64'(add_count), 64'(result_count));
        error_count += dut0.assert0.fail_count;

        $display("results: %0d, errors: %0d", result_count, error_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- verilog/accum_ctrl.sv
/*
 * Accumulator control: input handshake, clear, busy tracking and the
 * running sum register with its sticky truncation flag
 */
`timescale 1ns/1ps

module accum_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic                    clear,
    input  accum_pkg::value_in_t    in_value,
    output logic                    in_ready,
    output logic                    result_valid,
    output logic                    busy,
    output logic                    truncated,
    output accum_pkg::value_acc_t   result,
    output logic                    op_valid,
    output accum_pkg::value_acc_t   op_new,
    output accum_pkg::value_acc_t   op_acc,
    input  logic                    sum_valid,
    input  accum_pkg::value_acc_t   sum_value,
    input  logic                    sum_lost
);

    localparam accum_pkg::value_acc_t zero_value = '{
        sign:     1'b0,
        scale:    '0,
        fraction: '0,
        inf:      1'b0,
        zero:     1'b1
    };

    logic                   accept;
    logic                   clear_accept;
    accum_pkg::value_acc_t  sum_q;

    // One addition in flight, each one needs the previous sum
    assign in_ready = ~busy;

    // Clear wins over a value offered in the same cycle
    assign clear_accept = clear & in_ready;
    assign accept       = in_valid & in_ready & ~clear;

    assign result = sum_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy         <= 1'b0;
            op_valid     <= 1'b0;
            result_valid <= 1'b0;
            truncated    <= 1'b0;
            sum_q        <= zero_value;
        end
        else
        begin
            op_valid     <= accept;
            result_valid <= sum_valid;

            if (accept)
                busy <= 1'b1;
            else if (sum_valid)
                busy <= 1'b0;

            if (clear_accept)
            begin
                sum_q     <= zero_value;
                truncated <= 1'b0;
            end
            else if (sum_valid)
            begin
                sum_q     <= sum_value;
                truncated <= truncated | sum_lost;
            end
        end
    end

    // Launch the widened input together with the current sum
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_new <= accum_pkg::widen(in_value);
            op_acc <= sum_q;
        end
    end

endmodule

//--- verilog/accum_macros.svh
/*
 * Posit accumulator widths for es=2 unpacked values and the wide running sum
 */
`ifndef ACCUM_MACROS_SVH
`define ACCUM_MACROS_SVH

// Signed scale, regime and exponent together
`define ACC_SCALE_BITS 8

// Input fraction without the hidden bit
`define ACC_IN_FBITS 27

// Fraction of the running sum
`define ACC_FBITS 40

// Adder width: carry, hidden bit, fraction and one guard bit
`define ACC_ABITS 43

// Alignment shift and leading-zero counts, able to hold 0 .. ACC_ABITS
`define ACC_SHIFT_BITS 6

// Serialized widths, fields from MSB are sign, scale, fraction, inf, zero
`define ACC_IN_WIDTH 38
`define ACC_OUT_WIDTH 51

`endif

//--- verilog/accum_pkg.sv
/*
 * Accumulator types: unpacked input and sum values and the input widening
 */
`include "accum_macros.svh"

package accum_pkg;

    // Unpacked input value as handed in by the client
    typedef struct packed {
        logic                               sign;
        logic signed [`ACC_SCALE_BITS-1:0]  scale;
        logic [`ACC_IN_FBITS-1:0]           fraction;
        logic                               inf;
        logic                               zero;
    } value_in_t;

    // Same fields with the wide fraction of the running sum
    typedef struct packed {
        logic                               sign;
        logic signed [`ACC_SCALE_BITS-1:0]  scale;
        logic [`ACC_FBITS-1:0]              fraction;
        logic                               inf;
        logic                               zero;
    } value_acc_t;

    // Extra fraction bits are filled with zeros below the input fraction
    function automatic value_acc_t widen(input value_in_t v);
        value_acc_t w;
        w.sign     = v.sign;
        w.scale    = v.scale;
        w.fraction = {v.fraction, {(`ACC_FBITS - `ACC_IN_FBITS){1'b0}}};
        w.inf      = v.inf;
        w.zero     = v.zero;
        return w;
    endfunction

endpackage

//--- verilog/accum_stage_if.sv
/*
 * Aligned operand pair passed from the align stage to the sum stage
 */
`timescale 1ns/1ps
`include "accum_macros.svh"

interface accum_stage_if;

    // Marks the single cycle in which the payload holds
    logic                       valid;

    // Larger operand, its sign and scale carry into the sum
    accum_pkg::value_acc_t      hi;

    // Smaller operand after alignment
    logic                       low_zero;
    logic                       low_inf;
    logic [`ACC_ABITS-1:0]      low_frac_shifted;

    // Signs differ
    logic                       subtract;

    // A 1 bit fell below the adder during alignment
    logic                       lost;

    modport align (
        output valid,
        output hi,
        output low_zero,
        output low_inf,
        output low_frac_shifted,
        output subtract,
        output lost
    );

    modport sum (
        input valid,
        input hi,
        input low_zero,
        input low_inf,
        input low_frac_shifted,
        input subtract,
        input lost
    );

endinterface

//--- verilog/operand_align.sv
/*
 * Operand align stage: orders the pair by magnitude and shifts the smaller
 * fraction right by the scale difference, flagging bits that fall off
 */
`timescale 1ns/1ps
`include "accum_macros.svh"

module operand_align (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_valid,
    input  accum_pkg::value_acc_t   op_new,
    input  accum_pkg::value_acc_t   op_acc,
    accum_stage_if.align            stage
);

    logic                               new_is_hi;
    accum_pkg::value_acc_t              hi_op;
    accum_pkg::value_acc_t              lo_op;
    logic signed [`ACC_SCALE_BITS:0]    scale_diff;
    logic [`ACC_SHIFT_BITS-1:0]         shift;
    logic [2*`ACC_ABITS-1:0]            shifted_wide;

    // A zero operand always counts as the smaller one
    always_comb
    begin
        if (op_acc.zero)
            new_is_hi = 1'b1;
        else if (op_new.zero)
            new_is_hi = 1'b0;
        else if (op_new.scale != op_acc.scale)
            new_is_hi = $signed(op_new.scale) > $signed(op_acc.scale);
        else
            new_is_hi = op_new.fraction >= op_acc.fraction;
    end

    assign hi_op = new_is_hi ? op_new : op_acc;
    assign lo_op = new_is_hi ? op_acc : op_new;

    assign scale_diff = $signed(hi_op.scale) - $signed(lo_op.scale);

    // Shifts of the full adder width or more leave nothing in range
    always_comb
    begin
        if (scale_diff < 0 || scale_diff >= `ACC_ABITS)
            shift = `ACC_SHIFT_BITS'(`ACC_ABITS);
        else
            shift = scale_diff[`ACC_SHIFT_BITS-1:0];
    end

    // Upper half lands in the adder, lower half catches what falls off
    assign shifted_wide = {1'b0, 1'b1, lo_op.fraction, 1'b0, {`ACC_ABITS{1'b0}}} >> shift;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            stage.valid <= 1'b0;
        else
            stage.valid <= op_valid;
    end

    always_ff @(posedge clk)
    begin
        if (op_valid)
        begin
            stage.hi               <= hi_op;
            stage.low_zero         <= lo_op.zero;
            stage.low_inf          <= lo_op.inf;
            stage.low_frac_shifted <= shifted_wide[2*`ACC_ABITS-1 -: `ACC_ABITS];
            stage.subtract         <= hi_op.sign ^ lo_op.sign;
            stage.lost             <= ~lo_op.zero & (|shifted_wide[`ACC_ABITS-1:0]);
        end
    end

endmodule

//--- verilog/posit_accum_top.sv
/*
 * Posit accumulator top: control, align stage and sum stages
 */
`timescale 1ns/1ps
`include "accum_macros.svh"

module posit_accum_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic                        clear,
    input  logic [`ACC_IN_WIDTH-1:0]    in_value,
    output logic                        in_ready,
    output logic                        result_valid,
    output logic                        busy,
    output logic                        truncated,
    output logic [`ACC_OUT_WIDTH-1:0]   result
);

    logic                   op_valid;
    accum_pkg::value_acc_t  op_new;
    accum_pkg::value_acc_t  op_acc;
    logic                   sum_valid;
    accum_pkg::value_acc_t  sum_value;
    logic                   sum_lost;

    accum_stage_if stage_if0 ();

    accum_ctrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .clear        (clear),
        .in_value     (in_value),
        .in_ready     (in_ready),
        .result_valid (result_valid),
        .busy         (busy),
        .truncated    (truncated),
        .result       (result),
        .op_valid     (op_valid),
        .op_new       (op_new),
        .op_acc       (op_acc),
        .sum_valid    (sum_valid),
        .sum_value    (sum_value),
        .sum_lost     (sum_lost)
    );

    operand_align align0 (
        .clk      (clk),
        .rst      (rst),
        .op_valid (op_valid),
        .op_new   (op_new),
        .op_acc   (op_acc),
        .stage    (stage_if0.align)
    );

    sum_normalize sum0 (
        .clk       (clk),
        .rst       (rst),
        .stage     (stage_if0.sum),
        .sum_valid (sum_valid),
        .sum_value (sum_value),
        .sum_lost  (sum_lost)
    );

endmodule

//--- verilog/sum_normalize.sv
/*
 * Sum stages: add or subtract the aligned fractions, then renormalize
 * around the leading one and fix scale, sign and flags
 */
`timescale 1ns/1ps
`include "accum_macros.svh"

module sum_normalize (
    input  logic                    clk,
    input  logic                    rst,
    accum_stage_if.sum              stage,
    output logic                    sum_valid,
    output accum_pkg::value_acc_t   sum_value,
    output logic                    sum_lost
);

    logic [`ACC_ABITS-1:0]              hi_mant;
    logic [`ACC_ABITS-1:0]              lo_mant;

    logic                               s1_valid;
    logic [`ACC_ABITS-1:0]              s1_sum;
    logic                               s1_sign;
    logic signed [`ACC_SCALE_BITS-1:0]  s1_scale;
    logic                               s1_inf;
    logic                               s1_lost;

    logic [`ACC_SHIFT_BITS-1:0]         lz;
    logic [`ACC_ABITS-1:0]              norm;
    logic signed [`ACC_SCALE_BITS+1:0]  scale_adj;
    logic                               sum_zero;

    // Leading zeros from the carry bit down, full width when all zero
    function automatic logic [`ACC_SHIFT_BITS-1:0] lead_zeros(input logic [`ACC_ABITS-1:0] v);
        logic [`ACC_SHIFT_BITS-1:0] count;
        count = `ACC_SHIFT_BITS'(`ACC_ABITS);
        for (int i = 0; i < `ACC_ABITS; i++)
        begin
            if (v[i])
                count = `ACC_SHIFT_BITS'(`ACC_ABITS - 1 - i);
        end
        return count;
    endfunction

    // Adder layout: carry, hidden bit, fraction, guard
    assign hi_mant = stage.hi.zero ? '0 : {1'b0, 1'b1, stage.hi.fraction, 1'b0};
    assign lo_mant = stage.low_zero ? '0 : stage.low_frac_shifted;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s1_valid  <= 1'b0;
            sum_valid <= 1'b0;
        end
        else
        begin
            s1_valid  <= stage.valid;
            sum_valid <= s1_valid;
        end
    end

    // Stage 1, hi is never below lo so the difference stays positive
    always_ff @(posedge clk)
    begin
        if (stage.valid)
        begin
            s1_sum   <= stage.subtract ? hi_mant - lo_mant : hi_mant + lo_mant;
            s1_sign  <= stage.hi.sign;
            s1_scale <= stage.hi.scale;
            s1_inf   <= stage.hi.inf | stage.low_inf;
            s1_lost  <= stage.lost;
        end
    end

    // Leading one moves to the carry position, so one leading zero keeps the scale
    assign lz        = lead_zeros(s1_sum);
    assign norm      = s1_sum << lz;
    assign scale_adj = s1_scale + 2'sd1 - $signed({1'b0, lz});
    assign sum_zero  = (s1_sum == '0);

    // Stage 2
    always_ff @(posedge clk)
    begin
        if (s1_valid)
        begin
            // Exact cancellation gives a plain positive zero
            sum_value.sign     <= s1_sign & ~sum_zero;
            sum_value.scale    <= sum_zero ? '0 : scale_adj[`ACC_SCALE_BITS-1:0];
            sum_value.fraction <= norm[`ACC_ABITS-2 -: `ACC_FBITS];
            sum_value.inf      <= s1_inf;
            sum_value.zero     <= sum_zero & ~s1_inf;
            sum_lost           <= s1_lost;
        end
    end

endmodule
